//--- source/cpu_macros.svh
////////////////////////////////////////////////////////////
// widths, RAM depth and opcode values of the accumulator CPU
// include wherever a width or an opcode value is needed
////////////////////////////////////////////////////////////
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_DATA_W     8
`define CPU_ADDR_W     4
`define CPU_RAM_DEPTH  16
`define CPU_T_STATES   5

// upper nibble of an instruction word
`define OP_LDA  4'd0
`define OP_ADD  4'd1
`define OP_SUB  4'd2
`define OP_STA  4'd3
`define OP_LDI  4'd4
`define OP_JMP  4'd5
`define OP_JC   4'd6
`define OP_JZ   4'd7
`define OP_OUT  4'd14
`define OP_HLT  4'd15

`endif

//--- source/cpu_pkg.sv
////////////////////////////////////////////////////////////
// shared types of the accumulator CPU
// control word, bus source select, ALU flags, RAM word views
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

    // who owns the internal bus this cycle
    // codes 6 and 7 are unused and flagged by the arbiter
    typedef enum logic [2:0] {
        SRC_NONE = 3'd0,
        SRC_PC   = 3'd1,
        SRC_RAM  = 3'd2,
        SRC_IR   = 3'd3,
        SRC_ALU  = 3'd4,
        SRC_ACC  = 3'd5
    } bus_src_t;

    // one control word per cycle, 14 bits
    typedef struct packed {
        bus_src_t src;
        logic     mar_load;
        logic     ram_write;
        logic     ir_load;
        logic     acc_load;
        logic     b_load;
        logic     out_load;
        logic     pc_load;
        logic     pc_inc;
        // subtract instead of add
        logic     alu_sub;
        // latch carry and zero with this A load
        logic     flag_load;
        logic     halt;
    } ctrl_word_t;

    typedef struct packed {
        logic carry;
        logic zero;
    } alu_flags_t;

    // instruction view, opcode in the upper nibble
    typedef struct packed {
        logic [`CPU_DATA_W-`CPU_ADDR_W-1:0] opcode;
        logic [`CPU_ADDR_W-1:0]             operand;
    } instr_t;

    // one RAM byte, read as data or as instruction
    typedef union packed {
        logic [`CPU_DATA_W-1:0] data;
        instr_t                 instr;
    } ram_word_u;

endpackage

`default_nettype wire

//--- source/control_block.sv
////////////////////////////////////////////////////////////
// sequencer of the accumulator CPU
// five T-states per instruction, opcode decode into one
// control word each cycle, sticky halt on HLT
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

module control_block import cpu_pkg::*; (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                run,
    input  wire logic [`CPU_DATA_W-`CPU_ADDR_W-1:0] opcode,
    input  alu_flags_t                               flags,
    output ctrl_word_t                               ctrl,
    output logic                                     halted
);

    localparam int TW = $clog2(`CPU_T_STATES);

    localparam logic [TW-1:0] T0 = TW'(0);
    localparam logic [TW-1:0] T1 = TW'(1);
    localparam logic [TW-1:0] T2 = TW'(2);
    localparam logic [TW-1:0] T3 = TW'(3);
    localparam logic [TW-1:0] T4 = TW'(`CPU_T_STATES - 1);

    logic [TW-1:0] tstate;
    logic          step;

    // machine advances only when released and not stopped
    assign step = run && !halted;

    // T-state counter, wraps after T4
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tstate <= T0;
        end else if (step) begin
            tstate <= (tstate == T4) ? T0 : tstate + TW'(1);
        end
    end

    // sticky until reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            halted <= 1'b0;
        end else if (ctrl.halt) begin
            halted <= 1'b1;
        end
    end

    always_comb begin
        ctrl = '0;
        if (step) begin
            case (tstate)
                // fetch, address phase
                T0: begin
                    ctrl.src      = SRC_PC;
                    ctrl.mar_load = 1'b1;
                end
                // fetch, IR load and PC bump
                T1: begin
                    ctrl.src     = SRC_RAM;
                    ctrl.ir_load = 1'b1;
                    ctrl.pc_inc  = 1'b1;
                end
                T2: begin
                    case (opcode)
                        // operand address for memory ops
                        `OP_LDA, `OP_ADD, `OP_SUB, `OP_STA: begin
                            ctrl.src      = SRC_IR;
                            ctrl.mar_load = 1'b1;
                        end
                        `OP_LDI: begin
                            ctrl.src      = SRC_IR;
                            ctrl.acc_load = 1'b1;
                        end
                        `OP_JMP: begin
                            ctrl.src     = SRC_IR;
                            ctrl.pc_load = 1'b1;
                        end
                        // conditional jumps on the last latched flags
                        `OP_JC: begin
                            ctrl.src     = SRC_IR;
                            ctrl.pc_load = flags.carry;
                        end
                        `OP_JZ: begin
                            ctrl.src     = SRC_IR;
                            ctrl.pc_load = flags.zero;
                        end
                        `OP_OUT: begin
                            ctrl.src      = SRC_ACC;
                            ctrl.out_load = 1'b1;
                        end
                        `OP_HLT: ctrl.halt = 1'b1;
                        default: ;
                    endcase
                end
                T3: begin
                    case (opcode)
                        `OP_LDA: begin
                            ctrl.src      = SRC_RAM;
                            ctrl.acc_load = 1'b1;
                        end
                        `OP_ADD, `OP_SUB: begin
                            ctrl.src    = SRC_RAM;
                            ctrl.b_load = 1'b1;
                        end
                        `OP_STA: begin
                            ctrl.src       = SRC_ACC;
                            ctrl.ram_write = 1'b1;
                        end
                        default: ;
                    endcase
                end
                T4: begin
                    // result back into A, flags with it
                    if (opcode == `OP_ADD || opcode == `OP_SUB) begin
                        ctrl.src       = SRC_ALU;
                        ctrl.acc_load  = 1'b1;
                        ctrl.flag_load = 1'b1;
                        ctrl.alu_sub   = (opcode == `OP_SUB);
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/bus_arbiter.sv
////////////////////////////////////////////////////////////
// internal bus multiplexer
// one source per cycle from the control word's source field,
// unknown codes drive zero and flag a conflict
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

module bus_arbiter import cpu_pkg::*; (
    input  bus_src_t                      src,
    input  wire logic [`CPU_ADDR_W-1:0]   pc_value,
    input  wire logic [`CPU_DATA_W-1:0]   ram_value,
    input  wire logic [`CPU_ADDR_W-1:0]   ir_operand,
    input  wire logic [`CPU_DATA_W-1:0]   alu_value,
    input  wire logic [`CPU_DATA_W-1:0]   acc_value,
    output logic      [`CPU_DATA_W-1:0]   bus,
    output logic                          bus_conflict
);

    localparam int PAD_W = `CPU_DATA_W - `CPU_ADDR_W;

    always_comb begin
        bus          = '0;
        bus_conflict = 1'b0;
        case (src)
            // idle bus reads as zero
            SRC_NONE: bus = '0;
            // 4-bit sources sit in the low nibble
            SRC_PC:   bus = {{PAD_W{1'b0}}, pc_value};
            SRC_RAM:  bus = ram_value;
            SRC_IR:   bus = {{PAD_W{1'b0}}, ir_operand};
            SRC_ALU:  bus = alu_value;
            SRC_ACC:  bus = acc_value;
            default: begin
                bus          = '0;
                bus_conflict = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- source/alu_unit.sv
////////////////////////////////////////////////////////////
// accumulator, B register and adder/subtractor
// result is always presented for the bus, carry and zero
// latch only when A takes the ALU result
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

module alu_unit import cpu_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic [`CPU_DATA_W-1:0]  bus,
    input  ctrl_word_t                   ctrl,
    output logic      [`CPU_DATA_W-1:0]  acc_value,
    output logic      [`CPU_DATA_W-1:0]  alu_value,
    output alu_flags_t                   flags
);

    logic [`CPU_DATA_W-1:0] b_reg;
    // one spare bit on top for the carry out
    logic [`CPU_DATA_W:0]   sum;

    // accumulator
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_value <= '0;
        end else if (ctrl.acc_load) begin
            acc_value <= bus;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.b_load) begin
            b_reg <= bus;
        end
    end

    // subtract as A + ~B + 1, carry out then means no borrow
    always_comb begin
        if (ctrl.alu_sub) begin
            sum = {1'b0, acc_value} + {1'b0, ~b_reg} + 1'b1;
        end else begin
            sum = {1'b0, acc_value} + {1'b0, b_reg};
        end
    end

    assign alu_value = sum[`CPU_DATA_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (ctrl.flag_load) begin
            flags.carry <= sum[`CPU_DATA_W];
            flags.zero  <= (sum[`CPU_DATA_W-1:0] == '0);
        end
    end

endmodule

`default_nettype wire

//--- source/memory_unit.sv
////////////////////////////////////////////////////////////
// program counter, MAR, 16-byte RAM and instruction register
// RAM is filled through the load port while run is low and
// read combinationally at the MAR
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

module memory_unit import cpu_pkg::*; (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic [`CPU_DATA_W-1:0]              bus,
    input  ctrl_word_t                               ctrl,
    input  wire logic                                run,
    input  wire logic                                prog_we,
    input  wire logic [`CPU_ADDR_W-1:0]              prog_addr,
    input  wire logic [`CPU_DATA_W-1:0]              prog_data,
    output logic      [`CPU_ADDR_W-1:0]              pc_value,
    output logic      [`CPU_DATA_W-1:0]              ram_value,
    output logic      [`CPU_ADDR_W-1:0]              ir_operand,
    output logic      [`CPU_DATA_W-`CPU_ADDR_W-1:0] opcode
);

    logic [`CPU_ADDR_W-1:0] mar;
    ram_word_u              ram [`CPU_RAM_DEPTH];
    ram_word_u              ir;

    // PC, a jump wins over the increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_value <= '0;
        end else if (ctrl.pc_load) begin
            pc_value <= bus[`CPU_ADDR_W-1:0];
        end else if (ctrl.pc_inc) begin
            pc_value <= pc_value + 1'b1;
        end
    end

    // address comes from the low nibble of the bus
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (ctrl.mar_load) begin
            mar <= bus[`CPU_ADDR_W-1:0];
        end
    end

    // STA path from the bus, else program loading while stopped
    always_ff @(posedge clk) begin
        if (ctrl.ram_write) begin
            ram[mar].data <= bus;
        end else if (!run && prog_we) begin
            ram[prog_addr].data <= prog_data;
        end
    end

    assign ram_value = ram[mar].data;

    // IR takes the fetched byte whole
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (ctrl.ir_load) begin
            ir.data <= bus;
        end
    end

    // decoded through the instruction view
    assign opcode     = ir.instr.opcode;
    assign ir_operand = ir.instr.operand;

endmodule

`default_nettype wire

//--- source/cpu_top.sv
////////////////////////////////////////////////////////////
// top level of the accumulator CPU
// sequencer, bus arbiter, ALU and memory on one 8-bit bus,
// plus the output register with its one-cycle strobe
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

module cpu_top import cpu_pkg::*; (
    input  wire logic                    clk,
    input  wire logic                    rst_n,
    input  wire logic                    run,
    input  wire logic                    prog_we,
    input  wire logic [`CPU_ADDR_W-1:0]  prog_addr,
    input  wire logic [`CPU_DATA_W-1:0]  prog_data,
    output logic      [`CPU_DATA_W-1:0]  out_value,
    output logic                         out_strobe,
    output logic                         halted,
    output logic                         bus_conflict
);

    ctrl_word_t                          ctrl;
    alu_flags_t                          flags;
    logic [`CPU_DATA_W-1:0]              bus;
    logic [`CPU_DATA_W-`CPU_ADDR_W-1:0] opcode;
    logic [`CPU_ADDR_W-1:0]              pc_value;
    logic [`CPU_ADDR_W-1:0]              ir_operand;
    logic [`CPU_DATA_W-1:0]              ram_value;
    logic [`CPU_DATA_W-1:0]              alu_value;
    logic [`CPU_DATA_W-1:0]              acc_value;

    control_block cb_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .run    (run),
        .opcode (opcode),
        .flags  (flags),
        .ctrl   (ctrl),
        .halted (halted)
    );

    bus_arbiter arb_i (
        .src          (ctrl.src),
        .pc_value     (pc_value),
        .ram_value    (ram_value),
        .ir_operand   (ir_operand),
        .alu_value    (alu_value),
        .acc_value    (acc_value),
        .bus          (bus),
        .bus_conflict (bus_conflict)
    );

    alu_unit alu_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .ctrl      (ctrl),
        .acc_value (acc_value),
        .alu_value (alu_value),
        .flags     (flags)
    );

    memory_unit mem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .bus        (bus),
        .ctrl       (ctrl),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .pc_value   (pc_value),
        .ram_value  (ram_value),
        .ir_operand (ir_operand),
        .opcode     (opcode)
    );

    // output stage, value and strobe change on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_value  <= '0;
            out_strobe <= 1'b0;
        end else begin
            out_strobe <= ctrl.out_load;
            if (ctrl.out_load) begin
                out_value <= bus;
            end
        end
    end

endmodule

`default_nettype wire

//--- test/tb_clock.sv
////////////////////////////////////////////////////////////
// clock and reset source for the CPU testbench
// 100-unit clock period, reset low for four cycles at start
// and again after each reset_req pulse
////////////////////////////////////////////////////////////
`default_nettype none

module tb_clock (
    input  wire logic reset_req,
    output logic      clk,
    output logic      rst_n
);

    logic [2:0] rst_cycles;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // reset counter, saturates at 4 once reset is released
    initial rst_cycles = 3'd0;
    always @(posedge clk) begin
        if (reset_req) begin
            rst_cycles <= 3'd0;
        end else if (rst_cycles != 3'd4) begin
            rst_cycles <= rst_cycles + 3'd1;
        end
    end

    assign rst_n = (rst_cycles == 3'd4);

endmodule

`default_nettype wire

//--- test/cpu_asserts.sv
////////////////////////////////////////////////////////////
// concurrent checks on the CPU top level
// bound into cpu_top, watches bus ownership, strobe width,
// halt stickiness and the idle control word
////////////////////////////////////////////////////////////
`default_nettype none

module cpu_asserts import cpu_pkg::*; (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic run,
    input  ctrl_word_t ctrl,
    input  wire logic out_strobe,
    input  wire logic halted,
    input  wire logic bus_conflict
);

    // one source field, so a conflict means a bad encoding
    no_conflict_a: assert property (
        @(posedge clk) disable iff (!rst_n) !bus_conflict
    ) else $error("bus conflict on the internal bus");

    // strobe is a single-cycle pulse
    strobe_width_a: assert property (
        @(posedge clk) disable iff (!rst_n) out_strobe |=> !out_strobe
    ) else $error("out_strobe held for more than one cycle");

    // only reset clears halt
    halt_sticky_a: assert property (
        @(posedge clk) disable iff (!rst_n) halted |=> halted
    ) else $error("halted fell without reset");

    // stopped machine issues no control
    idle_ctrl_a: assert property (
        @(posedge clk) disable iff (!rst_n) !run |-> (ctrl == '0)
    ) else $error("control word active while run is low");

endmodule

bind cpu_top cpu_asserts asserts_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .ctrl         (ctrl),
    .out_strobe   (out_strobe),
    .halted       (halted),
    .bus_conflict (bus_conflict)
);

`default_nettype wire

//--- test/cpu_tb.sv
////////////////////////////////////////////////////////////
// testbench of the accumulator CPU
// loads small programs through the load port, runs them and
// compares every output strobe with an instruction-level model
////////////////////////////////////////////////////////////
`default_nettype none

`include "cpu_macros.svh"

module cpu_tb import cpu_pkg::*; ();

    localparam int RESET_LIMIT = 20;
    localparam int RUN_LIMIT   = 2000;
    localparam int QUIET       = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   reset_req;
    logic                   run;
    logic                   prog_we;
    logic [`CPU_ADDR_W-1:0] prog_addr;
    logic [`CPU_DATA_W-1:0] prog_data;
    logic [`CPU_DATA_W-1:0] out_value;
    logic                   out_strobe;
    logic                   halted;
    logic                   bus_conflict;

    // program image and the outputs the model expects from it
    ram_word_u              image [`CPU_RAM_DEPTH];
    logic [`CPU_DATA_W-1:0] exp_q [$];
    logic [15:0]            lfsr;
    string                  test_name;
    int                     test_errs;
    int                     err_count;
    int                     tests_run;
    int                     tests_passed;
    bit                     timed_out;

    tb_clock clk_i (
        .reset_req (reset_req),
        .clk       (clk),
        .rst_n     (rst_n)
    );

    cpu_top dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .run          (run),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .out_value    (out_value),
        .out_strobe   (out_strobe),
        .halted       (halted),
        .bus_conflict (bus_conflict)
    );

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [7:0] rand_bits(input int n);
        logic [7:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    function automatic ram_word_u encode(input logic [3:0] op, input logic [3:0] arg);
        ram_word_u w;
        w.instr.opcode  = op;
        w.instr.operand = arg;
        return w;
    endfunction

    // NOP filler (opcode 8) carrying its own address in the low nibble
    function automatic void fill_image();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            image[i] = encode(4'h8, 4'(i));
        end
    endfunction

    // instruction-level model filling exp_q and returning 1 on HLT
    function automatic bit run_model();
        ram_word_u  mem [`CPU_RAM_DEPTH];
        ram_word_u  w;
        logic [3:0] pc;
        logic [7:0] a;
        logic [7:0] b;
        bit         carry;
        bit         zero;
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            mem[i] = image[i];
        end
        exp_q.delete();
        pc    = '0;
        a     = '0;
        carry = 1'b0;
        zero  = 1'b0;
        for (int steps = 0; steps < 256; steps++) begin
            w  = mem[pc];
            pc = pc + 4'd1;
            case (w.instr.opcode)
                `OP_LDA: a = mem[w.instr.operand].data;
                `OP_ADD: begin
                    b     = mem[w.instr.operand].data;
                    carry = (int'(a) + int'(b)) > 255;
                    a     = a + b;
                    zero  = (a == 8'h00);
                end
                // carry set means no borrow
                `OP_SUB: begin
                    b     = mem[w.instr.operand].data;
                    carry = (a >= b);
                    a     = a - b;
                    zero  = (a == 8'h00);
                end
                `OP_STA: mem[w.instr.operand].data = a;
                `OP_LDI: a = {4'h0, w.instr.operand};
                `OP_JMP: pc = w.instr.operand;
                `OP_JC:  if (carry) pc = w.instr.operand;
                `OP_JZ:  if (zero) pc = w.instr.operand;
                `OP_OUT: exp_q.push_back(a);
                `OP_HLT: return 1'b1;
                default: ;
            endcase
        end
        return 1'b0;
    endfunction

    task automatic reset_cpu();
        int cyc;
        @(posedge clk);
        reset_req <= 1'b1;
        run       <= 1'b0;
        @(posedge clk);
        reset_req <= 1'b0;
        @(posedge clk);
        cyc = 0;
        while (!rst_n && cyc < RESET_LIMIT) begin
            @(posedge clk);
            cyc++;
        end
        if (!rst_n) begin
            $display("timeout: reset not released within %0d cycles", RESET_LIMIT);
            timed_out = 1'b1;
        end
    endtask

    // one byte per cycle through the load port
    task automatic load_image();
        for (int i = 0; i < `CPU_RAM_DEPTH; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 4'(i);
            prog_data <= image[i].data;
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_program(input string name, input int quiet);
        bit exp_halt;
        int cyc;
        test_name = name;
        test_errs = 0;
        exp_halt  = run_model();
        reset_cpu();
        if (!timed_out) begin
            if (out_value !== 8'h00) begin
                $display("[FAIL] %s reset out_value: expected 0, actual %0d", name, out_value);
                test_errs++;
            end
            if (out_strobe !== 1'b0) begin
                $display("[FAIL] %s reset out_strobe: expected 0, actual %0b", name, out_strobe);
                test_errs++;
            end
            if (halted !== 1'b0) begin
                $display("[FAIL] %s reset halted: expected 0, actual %0b", name, halted);
                test_errs++;
            end
            load_image();
            @(posedge clk);
            run <= 1'b1;
            cyc = 0;
            while (!halted && cyc < RUN_LIMIT) begin
                @(posedge clk);
                cyc++;
            end
            if (!halted) begin
                $display("timeout: %s did not halt within %0d cycles", name, RUN_LIMIT);
                timed_out = 1'b1;
            end else begin
                // late strobes land in the comparator as unexpected
                repeat (quiet) @(posedge clk);
                if (!exp_halt) begin
                    $display("%s: CPU halted but the model never reached HLT", name);
                    test_errs++;
                end
                if (exp_q.size() != 0) begin
                    $display("%s: %0d expected outputs never appeared", name, exp_q.size());
                    test_errs++;
                end
            end
            run <= 1'b0;
        end
        tests_run++;
        err_count += test_errs;
        if (test_errs == 0 && !timed_out) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: FAIL with %0d errors", name, test_errs);
        end
    endtask

    // every strobe checked against the model's next value
    always @(posedge clk) begin
        logic [7:0] exp_v;
        // the internal bus must never see two owners
        if (rst_n && bus_conflict !== 1'b0) begin
            $display("%s: bus_conflict raised on the internal bus", test_name);
            test_errs++;
        end
        if (rst_n && out_strobe) begin
            if (exp_q.size() == 0) begin
                $display("%s: out_strobe with value %0d where none was expected",
                         test_name, out_value);
                test_errs++;
            end else begin
                exp_v = exp_q.pop_front();
                if (out_value !== exp_v) begin
                    $display("[FAIL] %s out_value: expected %0d, actual %0d",
                             test_name, exp_v, out_value);
                    test_errs++;
                end
            end
        end
    end

    task automatic ldi_out_hlt();
        logic [3:0] k;
        k = 4'(rand_bits(4));
        fill_image();
        image[0] = encode(`OP_LDI, k);
        image[1] = encode(`OP_OUT, 4'd0);
        image[2] = encode(`OP_HLT, 4'd0);
        run_program("ldi_out_hlt", QUIET);
    endtask

    task automatic add_and_sub();
        for (int i = 0; i < 4 && !timed_out; i++) begin
            fill_image();
            image[0] = encode(`OP_LDA, 4'd14);
            image[1] = encode(`OP_ADD, 4'd15);
            image[2] = encode(`OP_OUT, 4'd0);
            image[3] = encode(`OP_LDA, 4'd14);
            image[4] = encode(`OP_SUB, 4'd15);
            image[5] = encode(`OP_OUT, 4'd0);
            image[6] = encode(`OP_HLT, 4'd0);
            // first pass forces the sum past 255
            image[14].data = rand_bits(8) | ((i == 0) ? 8'h80 : 8'h00);
            image[15].data = rand_bits(8) | ((i == 0) ? 8'h80 : 8'h00);
            run_program($sformatf("add_sub_%0d", i), QUIET);
        end
    endtask

    task automatic store_then_load();
        fill_image();
        image[0]       = encode(`OP_LDA, 4'd15);
        image[1]       = encode(`OP_STA, 4'd13);
        image[2]       = encode(`OP_LDI, 4'd0);
        image[3]       = encode(`OP_LDA, 4'd13);
        image[4]       = encode(`OP_OUT, 4'd0);
        image[5]       = encode(`OP_HLT, 4'd0);
        image[15].data = rand_bits(8);
        run_program("sta_lda", QUIET);
    endtask

    task automatic conditional_jumps();
        logic [3:0] op;
        logic [7:0] a;
        logic [7:0] b;
        for (int i = 0; i < 6 && !timed_out; i++) begin
            op = (rand_bits(1) != 8'h00) ? `OP_SUB : `OP_ADD;
            a  = rand_bits(8);
            b  = rand_bits(8);
            // equal operands on SUB set both zero and carry
            if (i == 0) begin
                op = `OP_SUB;
                b  = a;
            end
            fill_image();
            image[0]       = encode(`OP_LDA, 4'd14);
            image[1]       = encode(op, 4'd15);
            image[2]       = encode(`OP_OUT, 4'd0);
            image[3]       = encode(`OP_JC, 4'd6);
            image[4]       = encode(`OP_LDI, 4'd1);
            image[5]       = encode(`OP_OUT, 4'd0);
            image[6]       = encode(`OP_JZ, 4'd9);
            image[7]       = encode(`OP_LDI, 4'd2);
            image[8]       = encode(`OP_OUT, 4'd0);
            image[9]       = encode(`OP_LDI, 4'd3);
            image[10]      = encode(`OP_OUT, 4'd0);
            image[11]      = encode(`OP_HLT, 4'd0);
            image[14].data = a;
            image[15].data = b;
            run_program($sformatf("cond_jumps_%0d", i), QUIET);
        end
    endtask

    // counter at 13 runs the add loop eight times
    task automatic jump_loop();
        fill_image();
        image[0]       = encode(`OP_LDA, 4'd14);
        image[1]       = encode(`OP_ADD, 4'd15);
        image[2]       = encode(`OP_STA, 4'd14);
        image[3]       = encode(`OP_OUT, 4'd0);
        image[4]       = encode(`OP_LDA, 4'd13);
        image[5]       = encode(`OP_SUB, 4'd12);
        image[6]       = encode(`OP_STA, 4'd13);
        image[7]       = encode(`OP_JZ, 4'd9);
        image[8]       = encode(`OP_JMP, 4'd0);
        image[9]       = encode(`OP_HLT, 4'd0);
        image[12].data = 8'd1;
        image[13].data = 8'd8;
        image[14].data = rand_bits(8);
        image[15].data = rand_bits(8);
        run_program("jmp_loop", 2 * QUIET);
    endtask

    initial begin
        reset_req    <= 1'b0;
        run          <= 1'b0;
        prog_we      <= 1'b0;
        prog_addr    <= '0;
        prog_data    <= '0;
        lfsr          = 16'd21;
        test_errs     = 0;
        err_count     = 0;
        tests_run     = 0;
        tests_passed  = 0;
        timed_out     = 1'b0;

        ldi_out_hlt();
        if (!timed_out) add_and_sub();
        if (!timed_out) store_then_load();
        if (!timed_out) conditional_jumps();
        if (!timed_out) jump_loop();

        $display("tests run %0d, passed %0d, errors %0d", tests_run, tests_passed, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+source
source/cpu_pkg.sv
source/control_block.sv
source/bus_arbiter.sv
source/alu_unit.sv
source/memory_unit.sv
source/cpu_top.sv
test/tb_clock.sv
test/cpu_asserts.sv
test/cpu_tb.sv

//--- Makefile
# Verilator flow for the accumulator CPU testbench

VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert -Wno-fatal
PASS_MSG  ?= All checks passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# status comes from the pass line in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
